// File: src/cpu_ops_pkg.sv
// ==================================================
// Datapath control-word encodings for the 8-bit core
// Struct field order sets the bit layout the datapath
// decoders expect, MSB first
// ==================================================
`default_nettype none

package cpu_ops_pkg;

    // Address-bus modes, each named for the address it forms
    typedef enum logic [3:0] {
        AB_KEEP         = 4'b0000,  // AB + 0
        AB_PC           = 4'b0001,  // Back to PC
        AB_ABS_IDX      = 4'b0010,  // {DB, AHL + reg}, store PC
        AB_ZP_IDX       = 4'b0011,  // {00, DB + reg}
        AB_INC          = 4'b0100,  // AB + 1, store PC
        AB_SP_INC       = 4'b0101,  // {01, SP + 1}
        AB_BRANCH       = 4'b0111,  // AB + offset + 1
        AB_SP           = 4'b1000,  // {01, SP}, keep PC
        AB_SP_STORE     = 4'b1001,  // {01, SP}, store PC + 1
        AB_ABS_IDX_HOLD = 4'b1010,  // {DB, AHL + reg}, keep PC
        AB_SP_HOLD      = 4'b1011,  // {01, SP}, PC from AB
        AB_INC_HOLD     = 4'b1100,  // AB + 1, keep PC
        AB_ABS_IDX_INC  = 4'b1110,  // {DB, AHL + reg} + 1
        AB_VECTOR       = 4'b1111   // {FF, vector} + 1
    } ab_mode_e;

    typedef struct packed {
        logic [6:0] pc_sel;     // PC, hold and high-byte select
        logic [1:0] abl_sel;
        logic [1:0] abl_opnd;
        logic       abl_ci;
    } ab_op_t;

    typedef enum logic [3:0] {
        SRC_X      = 4'b0000,
        SRC_Y      = 4'b0001,
        SRC_A      = 4'b0010,
        SRC_S      = 4'b0011,
        SRC_ZERO   = 4'b0111,
        SRC_VECTOR = 4'b1010
    } reg_src_e;

    typedef enum logic [1:0] {DST_X, DST_Y, DST_A, DST_S} reg_dst_e;

    typedef struct packed {
        logic     write;
        reg_dst_e dst;
        reg_src_e src;
    } reg_op_t;

    typedef enum logic [2:0] {
        ALU_OR, ALU_AND, ALU_XOR, ALU_ADD, ALU_INC, ALU_DEC, ALU_SUB, ALU_TRB
    } alu_add_e;

    localparam logic [1:0] SH_NONE  = 2'b00;
    localparam logic [1:0] SH_LEFT  = 2'b10;
    localparam logic [1:0] SH_RIGHT = 2'b11;

    localparam logic [1:0] CY_0   = 2'b00;
    localparam logic [1:0] CY_1   = 2'b01;
    localparam logic [1:0] CY_ROT = 2'b10;  // Carry flag rotates in
    localparam logic [1:0] CY_ADC = 2'b11;

    typedef struct packed {
        logic       load_m;     // Memory operand from DB
        logic       bcd;
        logic [1:0] shift;
        alu_add_e   add;
        logic [1:0] carry;
    } alu_op_t;

endpackage

`default_nettype wire

// File: src/cpu_seq_pkg.sv
// ==================================================
// Sequencer types shared by the control blocks
// The decoded word holds datapath fields by scope
// ==================================================
`default_nettype none

package cpu_seq_pkg;

    localparam int state_w = 4;

    typedef enum logic [state_w-1:0] {
        INIT,
        SYNC,
        IMM0,
        ZERO,
        ABS0,
        ABS1,
        RDWR,
        DATA,
        PUSH,
        PULL,
        COND
    } ctl_state_e;

    // Opcodes the entry classifier picks out by value
    typedef enum logic [7:0] {
        OP_PHA = 8'h48,
        OP_JMP = 8'h4C,
        OP_PLA = 8'h68,
        OP_BRA = 8'h80
    } opcode_e;

    typedef struct packed {
        cpu_ops_pkg::reg_src_e src;
        cpu_ops_pkg::reg_dst_e dst;
        logic                  ld;      // Result written in next SYNC
        logic [6:0]            alu;     // {shift, add, carry}
        logic                  st;
        logic                  rmw;
        logic                  jmp;
    } insn_ctl_t;

endpackage

`default_nettype wire

// File: src/opcode_decoder.sv
// ==================================================
// Opcode table and entry-state classifier
// Reads db[7:0] only, so data_w must be at least 8
// Opcodes outside the table run as one-cycle no-ops
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module opcode_decoder import cpu_ops_pkg::*, cpu_seq_pkg::*; #(
    parameter int data_w = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              sync,
    input  logic [data_w-1:0] db,
    output ctl_state_e        entry_state,
    output insn_ctl_t         insn,
    output logic              add_x,
    output logic              add_y
);

    localparam insn_ctl_t insn_nop = '{src: SRC_ZERO, dst: DST_A, ld: 1'b0, alu: 7'd0,
                                       st: 1'b0, rmw: 1'b0, jmp: 1'b0};

    function automatic insn_ctl_t op_alu(input reg_src_e s, input reg_dst_e d,
                                         input logic w, input logic [1:0] sh,
                                         input alu_add_e add, input logic [1:0] cy);
        return '{src: s, dst: d, ld: w, alu: {sh, add, cy},
                 st: 1'b0, rmw: 1'b0, jmp: 1'b0};
    endfunction

    function automatic insn_ctl_t op_st(input reg_src_e s);
        return '{src: s, dst: DST_A, ld: 1'b0, alu: 7'd0, st: 1'b1, rmw: 1'b0, jmp: 1'b0};
    endfunction

    function automatic insn_ctl_t op_rmw(input logic [1:0] sh, input alu_add_e add,
                                         input logic [1:0] cy);
        return '{src: SRC_ZERO, dst: DST_A, ld: 1'b0, alu: {sh, add, cy},
                 st: 1'b0, rmw: 1'b1, jmp: 1'b0};
    endfunction

    logic [7:0] opc;
    insn_ctl_t  insn_d;
    logic       known;
    ctl_state_e cls;
    logic       idx_x;
    logic       idx_y;

    assign opc = db[7:0];

    always_comb begin
        insn_d = insn_nop;
        known  = 1'b1;
        case (opc)
            8'h0A: insn_d = op_alu(SRC_A, DST_A, 1'b1, SH_LEFT, ALU_OR, CY_0);    // ASL A
            8'h2A: insn_d = op_alu(SRC_A, DST_A, 1'b1, SH_LEFT, ALU_OR, CY_ROT);  // ROL A
            8'h4A: insn_d = op_alu(SRC_A, DST_A, 1'b1, SH_RIGHT, ALU_OR, CY_0);   // LSR A
            8'h6A: insn_d = op_alu(SRC_A, DST_A, 1'b1, SH_RIGHT, ALU_OR, CY_ROT); // ROR A
            8'h1A: insn_d = op_alu(SRC_A, DST_A, 1'b1, SH_NONE, ALU_INC, CY_1);   // INC A
            8'h3A: insn_d = op_alu(SRC_A, DST_A, 1'b1, SH_NONE, ALU_DEC, CY_0);   // DEC A
            8'hE8: insn_d = op_alu(SRC_X, DST_X, 1'b1, SH_NONE, ALU_INC, CY_1);   // INX
            8'hCA: insn_d = op_alu(SRC_X, DST_X, 1'b1, SH_NONE, ALU_DEC, CY_0);   // DEX
            8'hC8: insn_d = op_alu(SRC_Y, DST_Y, 1'b1, SH_NONE, ALU_INC, CY_1);   // INY
            8'h88: insn_d = op_alu(SRC_Y, DST_Y, 1'b1, SH_NONE, ALU_DEC, CY_0);   // DEY
            8'hAA: insn_d = op_alu(SRC_A, DST_X, 1'b1, SH_NONE, ALU_OR, CY_0);    // TAX
            8'hA8: insn_d = op_alu(SRC_A, DST_Y, 1'b1, SH_NONE, ALU_OR, CY_0);    // TAY
            8'h8A: insn_d = op_alu(SRC_X, DST_A, 1'b1, SH_NONE, ALU_OR, CY_0);    // TXA
            8'h98: insn_d = op_alu(SRC_Y, DST_A, 1'b1, SH_NONE, ALU_OR, CY_0);    // TYA
            8'h9A: insn_d = op_alu(SRC_X, DST_S, 1'b1, SH_NONE, ALU_OR, CY_0);    // TXS
            8'hBA: insn_d = op_alu(SRC_S, DST_X, 1'b1, SH_NONE, ALU_OR, CY_0);    // TSX
            8'h09, 8'h05, 8'h15, 8'h0D, 8'h1D, 8'h19:                             // ORA
                insn_d = op_alu(SRC_A, DST_A, 1'b1, SH_NONE, ALU_OR, CY_0);
            8'h29, 8'h25, 8'h35, 8'h2D, 8'h3D, 8'h39:                             // AND
                insn_d = op_alu(SRC_A, DST_A, 1'b1, SH_NONE, ALU_AND, CY_0);
            8'h49, 8'h45, 8'h55, 8'h4D, 8'h5D, 8'h59:                             // EOR
                insn_d = op_alu(SRC_A, DST_A, 1'b1, SH_NONE, ALU_XOR, CY_0);
            8'h69, 8'h65, 8'h75, 8'h6D, 8'h7D, 8'h79:                             // ADC
                insn_d = op_alu(SRC_A, DST_A, 1'b1, SH_NONE, ALU_ADD, CY_ADC);
            8'hE9, 8'hE5, 8'hF5, 8'hED, 8'hFD, 8'hF9:                             // SBC
                insn_d = op_alu(SRC_A, DST_A, 1'b1, SH_NONE, ALU_SUB, CY_ADC);
            8'hC9, 8'hC5, 8'hD5, 8'hCD, 8'hDD, 8'hD9:                             // CMP
                insn_d = op_alu(SRC_A, DST_A, 1'b0, SH_NONE, ALU_SUB, CY_1);
            8'hE0, 8'hE4, 8'hEC:                                                  // CPX
                insn_d = op_alu(SRC_X, DST_X, 1'b0, SH_NONE, ALU_SUB, CY_1);
            8'hC0, 8'hC4, 8'hCC:                                                  // CPY
                insn_d = op_alu(SRC_Y, DST_Y, 1'b0, SH_NONE, ALU_SUB, CY_1);
            8'hA9, 8'hA5, 8'hB5, 8'hAD, 8'hBD, 8'hB9, OP_PLA:                     // LDA
                insn_d = op_alu(SRC_ZERO, DST_A, 1'b1, SH_NONE, ALU_OR, CY_0);
            8'hA2, 8'hA6, 8'hB6, 8'hAE, 8'hBE:                                    // LDX
                insn_d = op_alu(SRC_ZERO, DST_X, 1'b1, SH_NONE, ALU_OR, CY_0);
            8'hA0, 8'hA4, 8'hB4, 8'hAC, 8'hBC:                                    // LDY
                insn_d = op_alu(SRC_ZERO, DST_Y, 1'b1, SH_NONE, ALU_OR, CY_0);
            8'h85, 8'h95, 8'h8D, 8'h9D, 8'h99, OP_PHA: insn_d = op_st(SRC_A);     // STA
            8'h86, 8'h96, 8'h8E: insn_d = op_st(SRC_X);                           // STX
            8'h84, 8'h94, 8'h8C: insn_d = op_st(SRC_Y);                           // STY
            8'h64, 8'h74, 8'h9C, 8'h9E: insn_d = op_st(SRC_ZERO);                 // STZ
            8'h06, 8'h16, 8'h0E, 8'h1E: insn_d = op_rmw(SH_LEFT, ALU_OR, CY_0);   // ASL
            8'h26, 8'h36, 8'h2E, 8'h3E: insn_d = op_rmw(SH_LEFT, ALU_OR, CY_ROT); // ROL
            8'h46, 8'h56, 8'h4E, 8'h5E: insn_d = op_rmw(SH_RIGHT, ALU_OR, CY_0);  // LSR
            8'h66, 8'h76, 8'h6E, 8'h7E: insn_d = op_rmw(SH_RIGHT, ALU_OR, CY_ROT);
            8'hE6, 8'hF6, 8'hEE, 8'hFE: insn_d = op_rmw(SH_NONE, ALU_INC, CY_1);  // INC
            8'hC6, 8'hD6, 8'hCE, 8'hDE: insn_d = op_rmw(SH_NONE, ALU_DEC, CY_0);  // DEC
            OP_JMP:  insn_d.jmp = 1'b1;
            OP_BRA:  known = 1'b1;          // Control word stays idle
            default: known = 1'b0;
        endcase
    end

    // First state after SYNC, mostly by opcode column
    always_comb begin
        casez (opc)
            OP_BRA:                 cls = COND;
            OP_PHA:                 cls = PUSH;
            OP_PLA:                 cls = PULL;
            8'b1010_00?0,
            8'b11?0_00?0,
            8'b???0_1001:           cls = IMM0;   // LDX/LDY/CPX/CPY #, col 9 even
            8'b???1_1001,
            8'b????_11??:           cls = ABS0;   // Col 9 odd, col c to f
            8'b????_01??:           cls = ZERO;
            default:                cls = SYNC;
        endcase
    end

    assign entry_state = known ? cls : SYNC;

    always_comb begin
        idx_x = 1'b0;
        idx_y = 1'b0;
        casez (opc)
            8'h96, 8'hB6, 8'hBE,
            8'b???1_1001:             idx_y = 1'b1;
            8'h9C:                    idx_x = 1'b0;   // STZ abs, not indexed
            8'b???1_01??, 8'b???1_11??: idx_x = 1'b1;
            default:                  idx_x = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            insn  <= insn_nop;
            add_x <= 1'b0;
            add_y <= 1'b0;
        end else if (sync) begin
            insn  <= insn_d;
            add_x <= idx_x;
            add_y <= idx_y;
        end
    end

endmodule

`default_nettype wire

// File: src/cycle_sequencer.sv
// ==================================================
// Bus-cycle state machine
// One INIT cycle follows reset, then SYNC
// insn must already hold the opcode fetched in SYNC
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module cycle_sequencer import cpu_seq_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  ctl_state_e entry_state,
    input  insn_ctl_t  insn,
    output ctl_state_e state,
    output logic       sync
);

    ctl_state_e state_nxt;

    always_comb begin
        case (state)
            INIT:       state_nxt = SYNC;
            SYNC:       state_nxt = entry_state;    // Picked by the decoder
            ABS0:       state_nxt = ABS1;
            ZERO:       state_nxt = insn.rmw ? RDWR : DATA;
            ABS1: begin
                if (insn.jmp)
                    state_nxt = SYNC;               // New PC is on the bus
                else
                    state_nxt = insn.rmw ? RDWR : DATA;
            end
            RDWR, PUSH, PULL:
                        state_nxt = DATA;
            default:    state_nxt = SYNC;           // IMM0, COND, DATA
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= INIT;
        else
            state <= state_nxt;
    end

    assign sync = (state == SYNC);

endmodule

`default_nettype wire

// File: src/addr_op_gen.sv
// ==================================================
// Address-bus control word from the bus state
// Branch direction uses the sign bit of db
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module addr_op_gen import cpu_ops_pkg::*, cpu_seq_pkg::*; #(
    parameter int data_w = 8
) (
    input  ctl_state_e        state,
    input  logic              cond,
    input  logic [data_w-1:0] db,
    output ab_op_t            ab_op
);

    ab_mode_e   mode;
    logic [6:0] hi_sel;
    logic [1:0] opnd;
    logic       back;

    assign back = cond & db[data_w-1];  // Taken backward branch

    always_comb begin
        case (state)
            SYNC, IMM0, ABS0: mode = AB_INC;
            ABS1:             mode = AB_ABS_IDX;
            ZERO:             mode = AB_ZP_IDX;
            DATA:             mode = AB_PC;
            PUSH:             mode = AB_SP_HOLD;
            PULL:             mode = AB_SP_INC;
            COND:             mode = AB_BRANCH;
            default:          mode = AB_KEEP;      // INIT, RDWR
        endcase
    end

    always_comb begin
        case (mode)
            AB_PC:           {hi_sel, opnd} = {7'b000_1010, 2'b10};
            AB_ABS_IDX:      {hi_sel, opnd} = {7'b111_1110, 2'b01};
            AB_ZP_IDX:       {hi_sel, opnd} = {7'b111_0000, 2'b01};
            AB_INC:          {hi_sel, opnd} = {7'b011_0110, 2'b11};
            AB_SP_INC:       {hi_sel, opnd} = {7'b011_0001, 2'b00};
            AB_BRANCH: begin
                if (back)
                    {hi_sel, opnd} = {7'b011_0111, 2'b11};  // High byte AB - 1
                else
                    {hi_sel, opnd} = {7'b011_0110, 2'b11};
            end
            AB_SP:           {hi_sel, opnd} = {7'b000_0001, 2'b00};
            AB_SP_STORE:     {hi_sel, opnd} = {7'b111_0001, 2'b00};
            AB_ABS_IDX_HOLD: {hi_sel, opnd} = {7'b001_1110, 2'b01};
            AB_SP_HOLD:      {hi_sel, opnd} = {7'b010_0001, 2'b00};
            AB_INC_HOLD:     {hi_sel, opnd} = {7'b001_0110, 2'b11};
            AB_ABS_IDX_INC:  {hi_sel, opnd} = {7'b001_1110, 2'b01};
            AB_VECTOR:       {hi_sel, opnd} = {7'b000_0011, 2'b00};
            default:         {hi_sel, opnd} = {7'b001_0110, 2'b11};  // AB_KEEP
        endcase
    end

    // Low mode bits select the ABL source, bit 2 is its carry in
    assign ab_op = '{pc_sel: hi_sel, abl_sel: mode[1:0], abl_opnd: opnd, abl_ci: mode[2]};

endmodule

`default_nettype wire

// File: src/datapath_ctl.sv
// ==================================================
// Register and ALU control words, and write strobe
// we is registered, so it is set in the cycle
// before DATA
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module datapath_ctl import cpu_ops_pkg::*, cpu_seq_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  ctl_state_e state,
    input  insn_ctl_t  insn,
    input  logic       add_x,
    input  logic       add_y,
    output reg_op_t    reg_op,
    output alu_op_t    alu_op,
    output logic       we
);

    localparam alu_op_t alu_idle  = '{load_m: 1'b0, bcd: 1'b0, shift: SH_NONE,
                                      add: ALU_OR, carry: CY_0};
    localparam alu_op_t alu_ldm   = '{load_m: 1'b1, bcd: 1'b0, shift: SH_NONE,
                                      add: ALU_OR, carry: CY_0};
    localparam alu_op_t alu_sp_dn = '{load_m: 1'b0, bcd: 1'b0, shift: SH_NONE,
                                      add: ALU_DEC, carry: CY_0};
    localparam alu_op_t alu_sp_up = '{load_m: 1'b0, bcd: 1'b0, shift: SH_NONE,
                                      add: ALU_INC, carry: CY_1};
    localparam alu_op_t alu_store = '{load_m: 1'b0, bcd: 1'b0, shift: SH_NONE,
                                      add: ALU_INC, carry: CY_0};

    reg_src_e idx_src;

    assign idx_src = add_x ? SRC_X : (add_y ? SRC_Y : SRC_ZERO);

    always_comb begin
        case (state)
            PUSH, PULL: reg_op = '{write: 1'b1, dst: DST_S, src: SRC_S};   // SP step
            ZERO, ABS1: reg_op = '{write: 1'b0, dst: DST_X, src: idx_src};
            SYNC:       reg_op = '{write: insn.ld, dst: insn.dst, src: insn.src};
            DATA:       reg_op = '{write: 1'b0, dst: insn.dst, src: insn.src};
            default:    reg_op = '{write: 1'b0, dst: DST_X, src: SRC_ZERO};
        endcase
    end

    always_comb begin
        case (state)
            PUSH:       alu_op = alu_sp_dn;
            PULL:       alu_op = alu_sp_up;
            IMM0, RDWR: alu_op = alu_ldm;
            SYNC:       alu_op = alu_op_t'({2'b00, insn.alu});    // Result of last insn
            DATA: begin
                if (insn.st)
                    alu_op = alu_store;
                else
                    alu_op = alu_op_t'({2'b10, insn.alu});        // Load or RMW
            end
            default:    alu_op = alu_idle;
        endcase
    end

    // High only in the DATA cycle of a store, RMW or push
    always_ff @(posedge clk) begin
        if (rst) begin
            we <= 1'b0;
        end else begin
            case (state)
                PUSH, RDWR: we <= 1'b1;
                ZERO, ABS1: we <= insn.st;    // RMW and JMP never set st
                default:    we <= 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/ctl_core.sv
// ==================================================
// Control unit top level for the 8-bit core
// db must be valid in every cycle
// No back-pressure, one instruction per sync pulse
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module ctl_core import cpu_ops_pkg::*, cpu_seq_pkg::*; #(
    parameter int data_w = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [data_w-1:0] db,
    input  logic              cond,
    output logic              sync,
    output logic              we,
    output ab_op_t            ab_op,
    output reg_op_t           reg_op,
    output alu_op_t           alu_op
);

    ctl_state_e entry_state;
    ctl_state_e state;
    insn_ctl_t  insn;
    logic       add_x;
    logic       add_y;

    opcode_decoder #(.data_w(data_w)) u_opcode_decoder (
        .clk         (clk),
        .rst         (rst),
        .sync        (sync),
        .db          (db),
        .entry_state (entry_state),
        .insn        (insn),
        .add_x       (add_x),
        .add_y       (add_y)
    );

    cycle_sequencer u_cycle_sequencer (
        .clk         (clk),
        .rst         (rst),
        .entry_state (entry_state),
        .insn        (insn),
        .state       (state),
        .sync        (sync)
    );

    addr_op_gen #(.data_w(data_w)) u_addr_op_gen (
        .state (state),
        .cond  (cond),
        .db    (db),
        .ab_op (ab_op)
    );

    datapath_ctl u_datapath_ctl (
        .clk    (clk),
        .rst    (rst),
        .state  (state),
        .insn   (insn),
        .add_x  (add_x),
        .add_y  (add_y),
        .reg_op (reg_op),
        .alu_op (alu_op),
        .we     (we)
    );

endmodule

`default_nettype wire

// File: test/ctl_ref.svh
// ==================================================
// Expected behavior of the control unit per opcode
// Classes follow the 6502 addressing columns
// Only opcodes of the test list are modeled
// ==================================================
`ifndef CTL_REF_SVH
`define CTL_REF_SVH

localparam int K_IMP  = 0;
localparam int K_IMM  = 1;
localparam int K_ZP   = 2;
localparam int K_ABS  = 3;
localparam int K_BRA  = 4;
localparam int K_PUSH = 5;
localparam int K_PULL = 6;
localparam int K_JMP  = 7;

typedef struct packed {
    logic    valid;     // Opcode writes a result in the next sync cycle
    reg_op_t r;
    alu_op_t a;
} sync_word_t;

function automatic int addr_kind(input logic [7:0] op);
    case (op)
        8'h00, 8'h20, 8'h40, 8'h60, 8'h6C, 8'hEA: return K_IMP;  // Dropped or unlisted
        8'h80: return K_BRA;
        8'h48: return K_PUSH;
        8'h68: return K_PULL;
        8'h4C: return K_JMP;
        8'hA0, 8'hA2, 8'hC0, 8'hE0: return K_IMM;
        default: ;
    endcase
    if (op[1:0] == 2'b01 && op[4:2] == 3'b010)
        return K_IMM;                           // Group one immediate
    if (op[3:2] == 2'b01)
        return K_ZP;
    if (op[3:2] == 2'b11 || (op[3:0] == 4'h9 && op[4]))
        return K_ABS;
    return K_IMP;
endfunction

function automatic logic is_rmw(input logic [7:0] op);
    return op[1:0] == 2'b10 && (op[3:2] == 2'b01 || op[3:2] == 2'b11) && op[7:6] != 2'b10;
endfunction

function automatic logic is_store(input logic [7:0] op);
    int k;
    k = addr_kind(op);
    if (op == 8'h64 || op == 8'h74)
        return 1'b1;                            // STZ zero page
    return op[7:5] == 3'b100 && (k == K_ZP || k == K_ABS);
endfunction

function automatic int exp_cycles(input logic [7:0] op);
    case (addr_kind(op))
        K_IMM, K_BRA:          return 2;
        K_ZP:                  return is_rmw(op) ? 4 : 3;
        K_ABS:                 return is_rmw(op) ? 5 : 4;
        K_PUSH, K_PULL, K_JMP: return 3;
        default:               return 1;
    endcase
endfunction

// Write strobe only in the last cycle, which is the DATA cycle
function automatic logic exp_we(input logic [7:0] op, input int idx);
    logic writes;
    writes = is_store(op) || is_rmw(op) || op == 8'h48;
    return writes && idx == exp_cycles(op) - 1;
endfunction

function automatic sync_word_t make_sync_word(input logic w, input reg_dst_e d,
                                              input reg_src_e s, input logic [1:0] sh,
                                              input alu_add_e add, input logic [1:0] cy);
    sync_word_t r;
    r.valid = 1'b1;
    r.r     = '{write: w, dst: d, src: s};
    r.a     = '{load_m: 1'b0, bcd: 1'b0, shift: sh, add: add, carry: cy};
    return r;
endfunction

function automatic sync_word_t exp_sync_word(input logic [7:0] op);
    sync_word_t r;
    r = '0;
    if (op[1:0] == 2'b01 && addr_kind(op) != K_IMP && !is_store(op)) begin
        case (op[7:5])                          // Group one operation field
            3'b000:  r = make_sync_word(1'b1, DST_A, SRC_A, SH_NONE, ALU_OR, CY_0);
            3'b001:  r = make_sync_word(1'b1, DST_A, SRC_A, SH_NONE, ALU_AND, CY_0);
            3'b010:  r = make_sync_word(1'b1, DST_A, SRC_A, SH_NONE, ALU_XOR, CY_0);
            3'b011:  r = make_sync_word(1'b1, DST_A, SRC_A, SH_NONE, ALU_ADD, CY_ADC);
            3'b101:  r = make_sync_word(1'b1, DST_A, SRC_ZERO, SH_NONE, ALU_OR, CY_0);
            3'b110:  r = make_sync_word(1'b0, DST_A, SRC_A, SH_NONE, ALU_SUB, CY_1);
            default: r = make_sync_word(1'b1, DST_A, SRC_A, SH_NONE, ALU_SUB, CY_ADC);
        endcase
    end
    case (op)
        8'h68: r = make_sync_word(1'b1, DST_A, SRC_ZERO, SH_NONE, ALU_OR, CY_0);  // PLA
        8'hA2, 8'hA6, 8'hB6, 8'hAE, 8'hBE:
            r = make_sync_word(1'b1, DST_X, SRC_ZERO, SH_NONE, ALU_OR, CY_0);
        8'hA0, 8'hA4, 8'hB4, 8'hAC, 8'hBC:
            r = make_sync_word(1'b1, DST_Y, SRC_ZERO, SH_NONE, ALU_OR, CY_0);
        8'hE0, 8'hE4, 8'hEC: r = make_sync_word(1'b0, DST_X, SRC_X, SH_NONE, ALU_SUB, CY_1);
        8'hC0, 8'hC4, 8'hCC: r = make_sync_word(1'b0, DST_Y, SRC_Y, SH_NONE, ALU_SUB, CY_1);
        8'hAA: r = make_sync_word(1'b1, DST_X, SRC_A, SH_NONE, ALU_OR, CY_0);
        8'hA8: r = make_sync_word(1'b1, DST_Y, SRC_A, SH_NONE, ALU_OR, CY_0);
        8'h8A: r = make_sync_word(1'b1, DST_A, SRC_X, SH_NONE, ALU_OR, CY_0);
        8'h98: r = make_sync_word(1'b1, DST_A, SRC_Y, SH_NONE, ALU_OR, CY_0);
        8'h9A: r = make_sync_word(1'b1, DST_S, SRC_X, SH_NONE, ALU_OR, CY_0);
        8'hBA: r = make_sync_word(1'b1, DST_X, SRC_S, SH_NONE, ALU_OR, CY_0);
        8'hE8: r = make_sync_word(1'b1, DST_X, SRC_X, SH_NONE, ALU_INC, CY_1);
        8'hCA: r = make_sync_word(1'b1, DST_X, SRC_X, SH_NONE, ALU_DEC, CY_0);
        8'hC8: r = make_sync_word(1'b1, DST_Y, SRC_Y, SH_NONE, ALU_INC, CY_1);
        8'h88: r = make_sync_word(1'b1, DST_Y, SRC_Y, SH_NONE, ALU_DEC, CY_0);
        8'h0A: r = make_sync_word(1'b1, DST_A, SRC_A, SH_LEFT, ALU_OR, CY_0);
        8'h2A: r = make_sync_word(1'b1, DST_A, SRC_A, SH_LEFT, ALU_OR, CY_ROT);
        8'h4A: r = make_sync_word(1'b1, DST_A, SRC_A, SH_RIGHT, ALU_OR, CY_0);
        8'h6A: r = make_sync_word(1'b1, DST_A, SRC_A, SH_RIGHT, ALU_OR, CY_ROT);
        8'h1A: r = make_sync_word(1'b1, DST_A, SRC_A, SH_NONE, ALU_INC, CY_1);
        8'h3A: r = make_sync_word(1'b1, DST_A, SRC_A, SH_NONE, ALU_DEC, CY_0);
        default: ;
    endcase
    return r;
endfunction

// Index register read while the operand address is formed
function automatic reg_op_t exp_index_reg(input logic [7:0] op);
    reg_op_t r;
    r.write = 1'b0;
    r.dst   = DST_X;
    if (op == 8'h96 || op == 8'hB6 || op == 8'hBE || op[3:0] == 4'h9)
        r.src = SRC_Y;
    else if (op[4] && op != 8'h9C)
        r.src = SRC_X;                          // STZ abs has bit 4 set but no index
    else
        r.src = SRC_ZERO;
    return r;
endfunction

function automatic ab_op_t exp_branch_ab(input logic c, input logic b7);
    ab_op_t ab;
    ab.pc_sel   = (c && b7) ? 7'b011_0111 : 7'b011_0110;  // Backward step lowers high byte
    ab.abl_sel  = 2'b11;                        // Branch mode is 4'b0111
    ab.abl_opnd = 2'b11;
    ab.abl_ci   = 1'b1;                         // Offset plus one
    return ab;
endfunction

`endif

// File: test/ctl_core_tb.sv
// ==================================================
// Random opcode stream against the reference model
// The stream is scheduled from predicted lengths
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module ctl_core_tb import cpu_ops_pkg::*; ();

    localparam int n_insn     = 300;
    localparam int period     = 40;
    localparam int rst_cycles = 8;

    logic       clk = 1'b0;
    logic       rst;
    logic [7:0] db;
    logic       cond;
    logic       sync;
    logic       we;
    ab_op_t     ab_op;
    reg_op_t    reg_op;
    alu_op_t    alu_op;

    integer     seed;
    int         errors;
    int         checks;
    int         reset_errors;
    int         n_done;
    logic [7:0] op_list [$];
    logic [7:0] cur_op;     // Opcode fetched at the last sync
    int         cyc;        // Cycles since that sync
    logic       init_done;
    logic       started;

    `include "ctl_ref.svh"

    ctl_core #(.data_w(8)) u_ctl_core (
        .clk    (clk),
        .rst    (rst),
        .db     (db),
        .cond   (cond),
        .sync   (sync),
        .we     (we),
        .ab_op  (ab_op),
        .reg_op (reg_op),
        .alu_op (alu_op)
    );

    always #(period / 2) clk = ~clk;

    task automatic check_ab_op(input string name, input ab_op_t act, input ab_op_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, act, exp, $time);
        end
    endtask

    task automatic check_reg_op(input string name, input reg_op_t act, input reg_op_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, act, exp, $time);
        end
    endtask

    task automatic check_alu_op(input string name, input alu_op_t act, input alu_op_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, act, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, act, exp, $time);
        end
    endtask

    task automatic drive_operand();
        integer rnd;
        rnd = $random(seed);
        db   <= rnd[7:0];
        cond <= rnd[8];
    endtask

    task automatic drive_opcode(input logic [7:0] op);
        integer rnd;
        rnd = $random(seed);
        db   <= op;
        cond <= rnd[0];
    endtask

    initial begin : stimulus
        logic [7:0] op;
        int         n;
        op_list = '{8'h0A, 8'h2A, 8'h4A, 8'h6A, 8'h1A, 8'h3A, 8'hE8, 8'hCA, 8'hC8, 8'h88,
                    8'hAA, 8'hA8, 8'h8A, 8'h98, 8'h9A, 8'hBA, 8'h09, 8'h29, 8'h49, 8'h69,
                    8'hE9, 8'hC9, 8'hA9, 8'hA2, 8'hA0, 8'hE0, 8'hC0, 8'h05, 8'h25, 8'h45,
                    8'h65, 8'hE5, 8'hC5, 8'hA5, 8'hA6, 8'hA4, 8'hE4, 8'hC4, 8'h15, 8'hB5,
                    8'hB6, 8'hB4, 8'h85, 8'h95, 8'h86, 8'h96, 8'h84, 8'h94, 8'h64, 8'h74,
                    8'h06, 8'h16, 8'h26, 8'h46, 8'h66, 8'h76, 8'hE6, 8'hD6, 8'h0D, 8'h1D,
                    8'h19, 8'hAD, 8'hBD, 8'hB9, 8'hAE, 8'hBE, 8'hAC, 8'hBC, 8'hCD, 8'hEC,
                    8'hCC, 8'h8D, 8'h9D, 8'h99, 8'h8E, 8'h8C, 8'h9C, 8'h9E, 8'h0E, 8'h1E,
                    8'h2E, 8'h4E, 8'h6E, 8'hEE, 8'hDE, 8'h4C, 8'h48, 8'h68, 8'h80, 8'h00,
                    8'h20, 8'h6C, 8'hEA};
        seed      = 32'h54a5_c208;
        rst       = 1'b1;
        db        = 8'h00;
        cond      = 1'b0;
        errors    = 0;
        checks    = 0;
        n_done    = 0;
        init_done = 1'b0;
        started   = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0;
        drive_operand();                        // INIT cycle
        for (n = 0; n < n_insn; n++) begin
            @(posedge clk);
            op = op_list[$unsigned($random(seed)) % op_list.size()];
            drive_opcode(op);
            repeat (exp_cycles(op) - 1) begin
                @(posedge clk);
                drive_operand();
            end
        end
        @(posedge clk);
        drive_opcode(8'hEA);                    // Closes the last gap
        @(posedge clk);
        $display("stream test: %0d instructions, %0d errors", n_done, errors - reset_errors);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    always @(negedge clk) begin : compare
        int         len;
        int         k;
        sync_word_t w;
        if (rst) begin
            check_bit("sync", sync, 1'b0);
            check_bit("we", we, 1'b0);
        end else if (!started) begin
            if (!init_done) begin
                check_bit("sync", sync, 1'b0);  // INIT cycle
                check_bit("we", we, 1'b0);
                init_done = 1'b1;
            end else begin
                if (!sync) begin
                    errors++;
                    $display("sync did not rise in the second cycle after reset");
                end
                started      = 1'b1;
                cur_op       = db;
                cyc          = 0;
                reset_errors = errors;
                $display("reset test: done, %0d errors", errors);
            end
        end else begin
            cyc = cyc + 1;
            len = exp_cycles(cur_op);
            k   = addr_kind(cur_op);
            if (cyc == len && !sync) begin
                errors++;
                $display("sync missing %0d cycles after opcode %h at %0t", len, cur_op, $time);
            end else begin
                check_bit("sync", sync, cyc == len);
            end
            if (sync) begin
                w = exp_sync_word(cur_op);      // Result write of the finished opcode
                if (w.valid) begin
                    check_reg_op("reg_op", reg_op, w.r);
                    check_alu_op("alu_op", alu_op, w.a);
                end
                n_done++;
                cur_op = db;
                cyc    = 0;
            end else if (k == K_BRA && cyc == 1) begin
                check_ab_op("ab_op", ab_op, exp_branch_ab(cond, db[7]));
            end else if ((k == K_ZP && cyc == 1) || ((k == K_ABS || k == K_JMP) && cyc == 2)) begin
                check_reg_op("reg_op", reg_op, exp_index_reg(cur_op));
            end
            check_bit("we", we, exp_we(cur_op, cyc));
        end
    end

    // Longest instruction is five cycles
    initial begin : watchdog
        #((rst_cycles + 2 + n_insn * 5 + 50) * period);
        $display("timeout: the opcode stream did not finish in time");
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: ctl_core.f
+incdir+test
src/cpu_ops_pkg.sv
src/cpu_seq_pkg.sv
src/opcode_decoder.sv
src/cycle_sequencer.sv
src/addr_op_gen.sv
src/datapath_ctl.sv
src/ctl_core.sv
test/ctl_core_tb.sv
